/* common/serv_pkg.sv */
package serv_pkg;

   // Data and address word
   typedef logic [31:0] word_t;

   // Register index
   typedef logic [4:0] reg_addr_t;

   // Bit position within a serial pass
   typedef logic [4:0] bit_cnt_t;

   // Instruction classes that the core executes
   typedef enum logic [2:0] {
      op_reg,
      op_imm,
      op_lui,
      op_jal,
      op_branch,
      op_load,
      op_store,
      op_other
   } opcode_e;

   typedef enum logic [1:0] {
      alu_add,
      alu_and,
      alu_or,
      alu_xor
   } alu_sel_e;

   // Source of the rd bit stream during write-back
   typedef enum logic [1:0] {
      rd_alu,
      rd_imm,
      rd_pc,
      rd_mem
   } rd_src_e;

   localparam word_t RESET_PC_DEFAULT = 32'h0000_0000;

endpackage

/* logic/serv_state.sv */
module serv_state import serv_pkg::*; (
   input  logic     clk,
   input  logic     i_rst_n,
   input  logic     i_ibus_ack,
   input  logic     i_dbus_ack,
   input  logic     i_two_pass,
   input  logic     i_mem_op,
   output logic     o_init,
   output logic     o_run,
   output logic     o_cnt_en,
   output bit_cnt_t o_cnt,
   output logic     o_cnt_done,
   output logic     o_fetch_req,
   output logic     o_dbus_cyc
);

   typedef enum logic [2:0] {
      st_idle,
      st_fetch,
      st_decode,
      st_init,
      st_mem,
      st_run
   } state_e;

   state_e   state_r;
   bit_cnt_t cnt_r;

   assign o_init     = (state_r == st_init);
   assign o_run      = (state_r == st_run);
   assign o_cnt_en   = o_init | o_run;
   assign o_cnt      = cnt_r;
   assign o_cnt_done = o_cnt_en & (cnt_r == 5'd31);
   assign o_dbus_cyc = (state_r == st_mem);

   // Next fetch goes out on the same edge that finishes the run pass
   assign o_fetch_req = (state_r == st_idle) | (o_run & o_cnt_done);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_r <= st_idle;
         cnt_r   <= '0;
      end else begin
         if (o_cnt_en) begin
            cnt_r <= cnt_r + 5'd1;
         end
         case (state_r)
            st_idle: state_r <= st_fetch;
            st_fetch: begin
               if (i_ibus_ack) begin
                  state_r <= st_decode;
               end
            end
            st_decode: state_r <= i_two_pass ? st_init : st_run;
            st_init: begin
               if (o_cnt_done) begin
                  state_r <= i_mem_op ? st_mem : st_run;
               end
            end
            st_mem: begin
               if (i_dbus_ack) begin
                  state_r <= st_run;
               end
            end
            st_run: begin
               if (o_cnt_done) begin
                  state_r <= st_fetch;
               end
            end
            default: state_r <= st_idle;
         endcase
      end
   end

endmodule

/* decode/serv_decode.sv */
module serv_decode import serv_pkg::*; (
   input  logic      clk,
   input  logic      i_rst_n,
   input  word_t     i_ibus_rdt,
   input  logic      i_ibus_ack,
   input  logic      i_ibus_cyc,
   input  bit_cnt_t  i_cnt,
   input  logic      i_cnt_en,
   input  logic      i_alu_eq,
   output logic      o_two_pass,
   output logic      o_mem_op,
   output logic      o_dbus_we,
   output alu_sel_e  o_alu_sel,
   output logic      o_alu_sub,
   output logic      o_imm_sel,
   output rd_src_e   o_rd_src,
   output logic      o_rd_en,
   output reg_addr_t o_rd_addr,
   output reg_addr_t o_rs1_addr,
   output reg_addr_t o_rs2_addr,
   output logic      o_imm,
   output logic      o_take_branch
);

   word_t      insn_r;
   word_t      imm_w;
   opcode_e    opcode;
   logic [6:0] major;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       f3_kept;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         insn_r <= '0;
      end else if (i_ibus_cyc && i_ibus_ack) begin
         insn_r <= i_ibus_rdt;
      end
   end

   assign major  = insn_r[6:0];
   assign funct3 = insn_r[14:12];
   assign funct7 = insn_r[31:25];

   // ADD/SUB, XOR, OR, AND
   assign f3_kept = (funct3 == 3'b000) | (funct3 == 3'b100) |
                    (funct3 == 3'b110) | (funct3 == 3'b111);

   always_comb begin
      opcode = op_other;
      case (major)
         7'b0110011: begin
            if (f3_kept && (funct7 == 7'b0000000 ||
                            (funct7 == 7'b0100000 && funct3 == 3'b000))) begin
               opcode = op_reg;
            end
         end
         7'b0010011: begin
            if (f3_kept) begin
               opcode = op_imm;
            end
         end
         7'b0110111: opcode = op_lui;
         7'b1101111: opcode = op_jal;
         7'b1100011: begin
            // BEQ and BNE only
            if (funct3[2:1] == 2'b00) begin
               opcode = op_branch;
            end
         end
         7'b0000011: begin
            if (funct3 == 3'b010) begin
               opcode = op_load;
            end
         end
         7'b0100011: begin
            if (funct3 == 3'b010) begin
               opcode = op_store;
            end
         end
         default: opcode = op_other;
      endcase
   end

   always_comb begin
      case (opcode)
         op_store:  imm_w = {{21{insn_r[31]}}, insn_r[30:25], insn_r[11:7]};
         op_branch: imm_w = {{20{insn_r[31]}}, insn_r[7], insn_r[30:25],
                             insn_r[11:8], 1'b0};
         op_lui:    imm_w = {insn_r[31:12], 12'b0};
         op_jal:    imm_w = {{12{insn_r[31]}}, insn_r[19:12], insn_r[20],
                             insn_r[30:21], 1'b0};
         default:   imm_w = {{21{insn_r[31]}}, insn_r[30:20]};
      endcase
   end

   assign o_imm = i_cnt_en & imm_w[i_cnt];

   always_comb begin
      case (funct3)
         3'b111:  o_alu_sel = alu_and;
         3'b110:  o_alu_sel = alu_or;
         3'b100:  o_alu_sel = alu_xor;
         default: o_alu_sel = alu_add;
      endcase
   end

   always_comb begin
      case (opcode)
         op_lui:  o_rd_src = rd_imm;
         op_jal:  o_rd_src = rd_pc;
         op_load: o_rd_src = rd_mem;
         default: o_rd_src = rd_alu;
      endcase
   end

   assign o_two_pass = (opcode == op_branch) | (opcode == op_load) | (opcode == op_store);
   assign o_mem_op   = (opcode == op_load) | (opcode == op_store);
   assign o_dbus_we  = (opcode == op_store);
   assign o_alu_sub  = (opcode == op_reg) & funct7[5];
   assign o_imm_sel  = (opcode == op_imm);
   assign o_rd_en    = (opcode == op_reg) | (opcode == op_imm) | (opcode == op_lui) |
                       (opcode == op_jal) | (opcode == op_load);

   assign o_rd_addr  = insn_r[11:7];
   assign o_rs1_addr = insn_r[19:15];
   assign o_rs2_addr = insn_r[24:20];

   // JAL always jumps, BNE inverts the equality result
   assign o_take_branch = (opcode == op_jal) |
                          ((opcode == op_branch) & (i_alu_eq ^ funct3[0]));

endmodule

/* logic/serv_bufreg.sv */
module serv_bufreg import serv_pkg::*; (
   input  logic  clk,
   input  logic  i_rst_n,
   input  logic  i_init,
   input  logic  i_cnt_en,
   input  logic  i_rs1,
   input  logic  i_imm,
   input  logic  i_rs1_en,
   output logic  o_q,
   output word_t o_adr
);

   word_t data_r;
   logic  carry_r;
   logic  a;
   logic  sum;
   logic  cout;

   assign a    = i_rs1 & i_rs1_en;
   assign sum  = a ^ i_imm ^ carry_r;
   assign cout = (a & i_imm) | (carry_r & (a ^ i_imm));

   // Carry only lives across the init pass
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_r <= 1'b0;
      end else if (i_cnt_en) begin
         carry_r <= i_init & cout;
      end else begin
         carry_r <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (i_cnt_en && i_init) begin
         data_r <= {sum, data_r[31:1]};
      end else if (i_cnt_en) begin
         // Rotate so the word is intact again after the run pass
         data_r <= {data_r[0], data_r[31:1]};
      end
   end

   assign o_q   = data_r[0];
   assign o_adr = data_r;

endmodule

/* logic/serv_ctrl.sv */
module serv_ctrl import serv_pkg::*; #(
   parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
   input  logic  clk,
   input  logic  i_rst_n,
   input  logic  i_fetch_req,
   input  logic  i_ibus_ack,
   input  logic  i_run,
   input  logic  i_cnt_en,
   input  logic  i_cnt_done,
   input  logic  i_jump,
   input  logic  i_imm,
   output word_t o_ibus_adr,
   output logic  o_ibus_cyc,
   output logic  o_pc_bit
);

   word_t      pc_r;
   logic [2:0] pos_r;
   logic       c4_r;
   logic       ct_r;
   logic       cyc_r;
   logic       en;
   logic       four;
   logic       p4_sum;
   logic       p4_cout;
   logic       tg_sum;
   logic       tg_cout;
   logic       new_bit;

   assign en = i_run & i_cnt_en;

   // One-hot position marker, bit 2 is the only set bit of the constant 4
   assign four = pos_r[2];

   assign p4_sum  = pc_r[0] ^ four ^ c4_r;
   assign p4_cout = (pc_r[0] & four) | (c4_r & (pc_r[0] ^ four));
   assign tg_sum  = pc_r[0] ^ i_imm ^ ct_r;
   assign tg_cout = (pc_r[0] & i_imm) | (ct_r & (pc_r[0] ^ i_imm));

   assign new_bit = i_jump ? tg_sum : p4_sum;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_r  <= RESET_PC;
         pos_r <= 3'b001;
         c4_r  <= 1'b0;
         ct_r  <= 1'b0;
         cyc_r <= 1'b0;
      end else begin
         if (en) begin
            pc_r <= {new_bit, pc_r[31:1]};
            if (i_cnt_done) begin
               pos_r <= 3'b001;
               c4_r  <= 1'b0;
               ct_r  <= 1'b0;
            end else begin
               pos_r <= {pos_r[1:0], 1'b0};
               c4_r  <= p4_cout;
               ct_r  <= tg_cout;
            end
         end
         if (i_fetch_req) begin
            cyc_r <= 1'b1;
         end else if (i_ibus_ack) begin
            cyc_r <= 1'b0;
         end
      end
   end

   assign o_ibus_adr = pc_r;
   assign o_ibus_cyc = cyc_r;

   // Return address for JAL
   assign o_pc_bit = p4_sum;

endmodule

/* logic/serv_alu.sv */
module serv_alu import serv_pkg::*; (
   input  logic     clk,
   input  logic     i_rst_n,
   input  logic     i_cnt_en,
   input  logic     i_init,
   input  logic     i_cnt_done,
   input  logic     i_rs1,
   input  logic     i_op_b,
   input  logic     i_sub,
   input  alu_sel_e i_sel,
   output logic     o_rd,
   output logic     o_eq
);

   logic first_r;
   logic carry_r;
   logic eq_r;
   logic b;
   logic cin;
   logic sum;
   logic cout;

   // Subtract is rs1 + ~b + 1, the +1 enters as carry on bit 0
   assign b    = i_op_b ^ i_sub;
   assign cin  = first_r ? i_sub : carry_r;
   assign sum  = i_rs1 ^ b ^ cin;
   assign cout = (i_rs1 & b) | (cin & (i_rs1 ^ b));

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         first_r <= 1'b1;
         carry_r <= 1'b0;
         eq_r    <= 1'b0;
      end else if (i_cnt_en) begin
         first_r <= i_cnt_done;
         carry_r <= cout;
         // Compare result is held from the init pass into the run pass
         if (i_init) begin
            eq_r <= (first_r | eq_r) & ~(i_rs1 ^ i_op_b);
         end
      end
   end

   always_comb begin
      case (i_sel)
         alu_and: o_rd = i_rs1 & i_op_b;
         alu_or:  o_rd = i_rs1 | i_op_b;
         alu_xor: o_rd = i_rs1 ^ i_op_b;
         default: o_rd = sum;
      endcase
   end

   assign o_eq = eq_r;

endmodule

/* logic/serv_rf.sv */
module serv_rf import serv_pkg::*; (
   input  logic      clk,
   input  logic      i_rst_n,
   input  bit_cnt_t  i_cnt,
   input  logic      i_cnt_en,
   input  logic      i_run,
   input  logic      i_rd_en,
   input  reg_addr_t i_rd_addr,
   input  reg_addr_t i_rs1_addr,
   input  reg_addr_t i_rs2_addr,
   input  logic      i_rd,
   output logic      o_rs1,
   output logic      o_rs2
);

   word_t regs [32];
   logic  wen;

   // x0 is never written, so it stays at its reset value of zero
   assign wen = i_run & i_cnt_en & i_rd_en & (i_rd_addr != 5'd0);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wen) begin
         regs[i_rd_addr][i_cnt] <= i_rd;
      end
   end

   // Reads see the old bit, so rd may equal rs1 or rs2
   assign o_rs1 = regs[i_rs1_addr][i_cnt];
   assign o_rs2 = regs[i_rs2_addr][i_cnt];

endmodule

/* logic/serv_mem_if.sv */
module serv_mem_if import serv_pkg::*; (
   input  logic       clk,
   input  logic       i_rst_n,
   input  logic       i_init,
   input  logic       i_cnt_en,
   input  logic       i_run,
   input  logic       i_rs2,
   input  logic       i_dbus_ack,
   input  word_t      i_dbus_rdt,
   output word_t      o_dbus_dat,
   output logic [3:0] o_dbus_sel,
   output logic       o_rd
);

   word_t dat_r;

   // One register holds store data on the way out and load data on the way in
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         dat_r <= '0;
      end else if (i_dbus_ack) begin
         dat_r <= i_dbus_rdt;
      end else if (i_cnt_en && i_init) begin
         dat_r <= {i_rs2, dat_r[31:1]};
      end else if (i_cnt_en && i_run) begin
         dat_r <= {1'b0, dat_r[31:1]};
      end
   end

   assign o_dbus_dat = dat_r;
   assign o_rd       = dat_r[0];

   // Word accesses only
   assign o_dbus_sel = 4'b1111;

endmodule

/* logic/serv_top.sv */
module serv_top import serv_pkg::*; #(
   parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
   input  logic       clk,
   input  logic       i_rst_n,
   output word_t      o_ibus_adr,
   output logic       o_ibus_cyc,
   input  word_t      i_ibus_rdt,
   input  logic       i_ibus_ack,
   output word_t      o_dbus_adr,
   output word_t      o_dbus_dat,
   output logic [3:0] o_dbus_sel,
   output logic       o_dbus_we,
   output logic       o_dbus_cyc,
   input  word_t      i_dbus_rdt,
   input  logic       i_dbus_ack
);

   logic      init;
   logic      run;
   logic      cnt_en;
   bit_cnt_t  cnt;
   logic      cnt_done;
   logic      fetch_req;
   logic      two_pass;
   logic      mem_op;
   alu_sel_e  alu_sel;
   logic      alu_sub;
   logic      imm_sel;
   rd_src_e   rd_src;
   logic      rd_en;
   reg_addr_t rd_addr;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   logic      imm;
   logic      take_branch;
   logic      alu_eq;
   logic      alu_rd;
   logic      rs1;
   logic      rs2;
   logic      op_b;
   logic      pc_bit;
   logic      mem_rd;
   logic      rd;

   assign op_b = imm_sel ? imm : rs2;

   always_comb begin
      case (rd_src)
         rd_imm:  rd = imm;
         rd_pc:   rd = pc_bit;
         rd_mem:  rd = mem_rd;
         default: rd = alu_rd;
      endcase
   end

   serv_state state (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_ibus_ack  (i_ibus_ack),
      .i_dbus_ack  (i_dbus_ack),
      .i_two_pass  (two_pass),
      .i_mem_op    (mem_op),
      .o_init      (init),
      .o_run       (run),
      .o_cnt_en    (cnt_en),
      .o_cnt       (cnt),
      .o_cnt_done  (cnt_done),
      .o_fetch_req (fetch_req),
      .o_dbus_cyc  (o_dbus_cyc)
   );

   serv_decode decode (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_ibus_rdt    (i_ibus_rdt),
      .i_ibus_ack    (i_ibus_ack),
      .i_ibus_cyc    (o_ibus_cyc),
      .i_cnt         (cnt),
      .i_cnt_en      (cnt_en),
      .i_alu_eq      (alu_eq),
      .o_two_pass    (two_pass),
      .o_mem_op      (mem_op),
      .o_dbus_we     (o_dbus_we),
      .o_alu_sel     (alu_sel),
      .o_alu_sub     (alu_sub),
      .o_imm_sel     (imm_sel),
      .o_rd_src      (rd_src),
      .o_rd_en       (rd_en),
      .o_rd_addr     (rd_addr),
      .o_rs1_addr    (rs1_addr),
      .o_rs2_addr    (rs2_addr),
      .o_imm         (imm),
      .o_take_branch (take_branch)
   );

   serv_bufreg bufreg (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_init   (init),
      .i_cnt_en (cnt_en),
      .i_rs1    (rs1),
      .i_imm    (imm),
      .i_rs1_en (mem_op),
      .o_q      (),
      .o_adr    (o_dbus_adr)
   );

   // Branch and JAL offsets come straight from the serial immediate
   serv_ctrl #(
      .RESET_PC (RESET_PC)
   ) ctrl (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_fetch_req (fetch_req),
      .i_ibus_ack  (i_ibus_ack),
      .i_run       (run),
      .i_cnt_en    (cnt_en),
      .i_cnt_done  (cnt_done),
      .i_jump      (take_branch),
      .i_imm       (imm),
      .o_ibus_adr  (o_ibus_adr),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_pc_bit    (pc_bit)
   );

   serv_alu alu (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_init     (init),
      .i_cnt_done (cnt_done),
      .i_rs1      (rs1),
      .i_op_b     (op_b),
      .i_sub      (alu_sub),
      .i_sel      (alu_sel),
      .o_rd       (alu_rd),
      .o_eq       (alu_eq)
   );

   serv_rf rf (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt      (cnt),
      .i_cnt_en   (cnt_en),
      .i_run      (run),
      .i_rd_en    (rd_en),
      .i_rd_addr  (rd_addr),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd       (rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   serv_mem_if mem_if (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_init     (init),
      .i_cnt_en   (cnt_en),
      .i_run      (run),
      .i_rs2      (rs2),
      .i_dbus_ack (i_dbus_ack),
      .i_dbus_rdt (i_dbus_rdt),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_sel (o_dbus_sel),
      .o_rd       (mem_rd)
   );

endmodule

/* testbench/serv_tb.sv */
module serv_tb import serv_pkg::*; ();

   localparam word_t RESET_PC        = RESET_PC_DEFAULT;
   localparam int    NUM_TESTS       = 6;
   localparam int    MAX_PROG        = 20;
   localparam int    CYCLES_PER_INSN = 200;

   logic       clk        = 1'b0;
   logic       i_rst_n    = 1'b0;
   word_t      i_ibus_rdt = '0;
   logic       i_ibus_ack = 1'b0;
   word_t      i_dbus_rdt = '0;
   logic       i_dbus_ack = 1'b0;
   word_t      o_ibus_adr;
   logic       o_ibus_cyc;
   word_t      o_dbus_adr;
   word_t      o_dbus_dat;
   logic [3:0] o_dbus_sel;
   logic       o_dbus_we;
   logic       o_dbus_cyc;

   word_t       mem [256];
   word_t       fetch_q[$];
   word_t       exp_fetch_q[$];
   word_t       st_adr_q[$];
   word_t       st_dat_q[$];
   word_t       ld_adr_q[$];
   word_t       sel_q[$];
   int unsigned ibus_wait;
   int unsigned dbus_wait;
   logic [7:0]  emit_idx;
   string       cur_test;
   int          n_checks;
   int          n_errors;

   serv_top #(
      .RESET_PC (RESET_PC)
   ) serv_top_inst (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_sel (o_dbus_sel),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack)
   );

   always #10 clk = ~clk;

   // Instruction port of the memory, one-cycle ack after 0 to 3 wait cycles
   always @(posedge clk) begin
      if (!i_rst_n) begin
         i_ibus_ack <= 1'b0;
         ibus_wait  <= 0;
      end else begin
         i_ibus_ack <= 1'b0;
         if (o_ibus_cyc && !i_ibus_ack) begin
            if (ibus_wait == 0) begin
               i_ibus_ack <= 1'b1;
               i_ibus_rdt <= mem[o_ibus_adr[9:2]];
               fetch_q.push_back(o_ibus_adr);
               ibus_wait  <= $urandom() % 4;
            end else begin
               ibus_wait <= ibus_wait - 1;
            end
         end
      end
   end

   // Data port, stores are only logged
   always @(posedge clk) begin
      if (!i_rst_n) begin
         i_dbus_ack <= 1'b0;
         dbus_wait  <= 0;
      end else begin
         i_dbus_ack <= 1'b0;
         if (o_dbus_cyc && !i_dbus_ack) begin
            if (dbus_wait == 0) begin
               i_dbus_ack <= 1'b1;
               sel_q.push_back({28'd0, o_dbus_sel});
               if (o_dbus_we) begin
                  st_adr_q.push_back(o_dbus_adr);
                  st_dat_q.push_back(o_dbus_dat);
               end else begin
                  i_dbus_rdt <= mem[o_dbus_adr[9:2]];
                  ld_adr_q.push_back(o_dbus_adr);
               end
               dbus_wait <= $urandom() % 4;
            end else begin
               dbus_wait <= dbus_wait - 1;
            end
         end
      end
   end

   // RV32I encodings
   function automatic word_t reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1,
                                    input reg_addr_t rs2);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic word_t imm_op(input logic [2:0] f3, input reg_addr_t rd,
                                    input reg_addr_t rs1, input logic [11:0] imm);
      return {imm, rs1, f3, rd, 7'b0010011};
   endfunction

   function automatic word_t load_op(input reg_addr_t rd, input reg_addr_t rs1,
                                     input logic [11:0] imm);
      return {imm, rs1, 3'b010, rd, 7'b0000011};
   endfunction

   function automatic word_t store_op(input reg_addr_t rs2, input reg_addr_t rs1,
                                      input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic word_t branch_op(input logic [2:0] f3, input reg_addr_t rs1,
                                       input reg_addr_t rs2, input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic word_t lui_op(input reg_addr_t rd, input logic [19:0] up);
      return {up, rd, 7'b0110111};
   endfunction

   function automatic word_t jal_op(input reg_addr_t rd, input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   function automatic word_t sext12(input logic [11:0] imm);
      return {{20{imm[11]}}, imm};
   endfunction

   task automatic check(input string what, input word_t exp, input word_t act);
      n_checks++;
      if (exp !== act) begin
         n_errors++;
         $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic emit(input word_t w);
      mem[emit_idx] = w;
      emit_idx      = emit_idx + 8'd1;
   endtask

   // LUI plus ADDI, upper part rounded for the sign of the low 12 bits
   task automatic load_const(input reg_addr_t rd, input word_t val);
      word_t up;
      up = val + 32'h800;
      emit(lui_op(rd, up[31:12]));
      emit(imm_op(3'b000, rd, rd, val[11:0]));
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      @(posedge clk);
      i_rst_n <= 1'b0;
      @(posedge clk);
      for (int i = 0; i < 256; i++) begin
         mem[i[7:0]] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h3c, 8'hc3};
      end
      emit_idx = RESET_PC[9:2];
      exp_fetch_q.delete();
   endtask

   task automatic run_program(input int n_stores);
      repeat (2) @(posedge clk);
      fetch_q.delete();
      st_adr_q.delete();
      st_dat_q.delete();
      ld_adr_q.delete();
      sel_q.delete();
      check("ibus cyc in reset", 32'd0, {31'd0, o_ibus_cyc});
      check("dbus cyc in reset", 32'd0, {31'd0, o_dbus_cyc});
      check("dbus we in reset", 32'd0, {31'd0, o_dbus_we});
      i_rst_n <= 1'b1;
      while (st_adr_q.size() < n_stores) begin
         @(posedge clk);
      end
      foreach (sel_q[k]) begin
         check($sformatf("dbus select %0d", k), 32'hf, sel_q[k]);
      end
   endtask

   task automatic check_store(input int k, input word_t adr, input word_t dat);
      check($sformatf("store %0d address", k), adr, st_adr_q[k]);
      check($sformatf("store %0d data", k), dat, st_dat_q[k]);
   endtask

   task automatic check_fetches();
      if (fetch_q.size() < exp_fetch_q.size()) begin
         n_errors++;
         $display("%s: only %0d instruction fetches seen, %0d expected",
                  cur_test, fetch_q.size(), exp_fetch_q.size());
      end else begin
         foreach (exp_fetch_q[k]) begin
            check($sformatf("fetch %0d address", k), exp_fetch_q[k], fetch_q[k]);
         end
      end
   endtask

   task automatic test_reset_pc();
      start_test("reset_pc");
      emit(imm_op(3'b000, 5'd1, 5'd0, 12'd5));
      emit(imm_op(3'b000, 5'd2, 5'd1, 12'd7));
      emit(store_op(5'd2, 5'd0, 12'h100));
      emit(jal_op(5'd0, 21'd0));
      for (int k = 0; k < 3; k++) begin
         exp_fetch_q.push_back(RESET_PC + 32'(4 * k));
      end
      run_program(1);
      check_fetches();
      check_store(0, 32'h100, 32'd12);
   endtask

   task automatic test_arith();
      word_t a;
      word_t b;
      start_test("arith");
      a = $urandom();
      b = $urandom();
      load_const(5'd1, a);
      load_const(5'd2, b);
      emit(reg_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
      emit(store_op(5'd3, 5'd0, 12'h100));
      emit(reg_op(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
      emit(store_op(5'd4, 5'd0, 12'h104));
      emit(imm_op(3'b000, 5'd5, 5'd0, 12'd3));
      emit(imm_op(3'b000, 5'd6, 5'd0, 12'd10));
      emit(reg_op(7'h20, 3'b000, 5'd7, 5'd5, 5'd6));
      emit(store_op(5'd7, 5'd0, 12'h108));
      // All ones plus one, carry runs through every bit
      emit(imm_op(3'b000, 5'd8, 5'd0, 12'hfff));
      emit(imm_op(3'b000, 5'd9, 5'd8, 12'd1));
      emit(store_op(5'd9, 5'd0, 12'h10c));
      emit(lui_op(5'd11, 20'habcde));
      emit(store_op(5'd11, 5'd0, 12'h110));
      emit(jal_op(5'd0, 21'd0));
      run_program(5);
      check_store(0, 32'h100, a + b);
      check_store(1, 32'h104, a - b);
      check_store(2, 32'h108, 32'd3 - 32'd10);
      check_store(3, 32'h10c, 32'hffff_ffff + 32'd1);
      check_store(4, 32'h110, {20'habcde, 12'h000});
   endtask

   task automatic test_logic();
      word_t       a;
      word_t       b;
      word_t       r;
      logic [11:0] imm;
      start_test("logic");
      a   = $urandom();
      b   = $urandom();
      r   = $urandom();
      imm = r[11:0];
      load_const(5'd1, a);
      load_const(5'd2, b);
      emit(reg_op(7'h00, 3'b111, 5'd3, 5'd1, 5'd2));
      emit(store_op(5'd3, 5'd0, 12'h100));
      emit(reg_op(7'h00, 3'b110, 5'd4, 5'd1, 5'd2));
      emit(store_op(5'd4, 5'd0, 12'h104));
      emit(reg_op(7'h00, 3'b100, 5'd5, 5'd1, 5'd2));
      emit(store_op(5'd5, 5'd0, 12'h108));
      emit(imm_op(3'b111, 5'd6, 5'd1, imm));
      emit(store_op(5'd6, 5'd0, 12'h10c));
      emit(imm_op(3'b110, 5'd7, 5'd1, imm));
      emit(store_op(5'd7, 5'd0, 12'h110));
      emit(imm_op(3'b100, 5'd8, 5'd1, imm));
      emit(store_op(5'd8, 5'd0, 12'h114));
      emit(jal_op(5'd0, 21'd0));
      run_program(6);
      check_store(0, 32'h100, a & b);
      check_store(1, 32'h104, a | b);
      check_store(2, 32'h108, a ^ b);
      check_store(3, 32'h10c, a & sext12(imm));
      check_store(4, 32'h110, a | sext12(imm));
      check_store(5, 32'h114, a ^ sext12(imm));
   endtask

   task automatic test_control_flow();
      word_t poison;
      word_t pc;
      start_test("control_flow");
      // Any skipped slot that runs anyway shows up as an extra store
      poison = store_op(5'd0, 5'd0, 12'h1f0);
      emit(imm_op(3'b000, 5'd1, 5'd0, 12'd5));
      emit(imm_op(3'b000, 5'd2, 5'd0, 12'd5));
      emit(branch_op(3'b000, 5'd1, 5'd2, 13'd8));
      emit(poison);
      emit(branch_op(3'b001, 5'd1, 5'd2, 13'd8));
      emit(imm_op(3'b000, 5'd3, 5'd0, 12'd7));
      emit(branch_op(3'b001, 5'd1, 5'd3, 13'd8));
      emit(poison);
      emit(branch_op(3'b000, 5'd1, 5'd3, 13'd8));
      emit(jal_op(5'd4, 21'd12));
      emit(poison);
      emit(poison);
      emit(store_op(5'd4, 5'd0, 12'h100));
      emit(jal_op(5'd0, 21'd0));
      pc = RESET_PC;
      exp_fetch_q.push_back(pc);
      exp_fetch_q.push_back(pc + 32'd4);
      exp_fetch_q.push_back(pc + 32'd8);
      // BEQ taken
      exp_fetch_q.push_back(pc + 32'd16);
      // BNE not taken
      exp_fetch_q.push_back(pc + 32'd20);
      exp_fetch_q.push_back(pc + 32'd24);
      // BNE taken
      exp_fetch_q.push_back(pc + 32'd32);
      // BEQ not taken, then JAL forward by 12
      exp_fetch_q.push_back(pc + 32'd36);
      exp_fetch_q.push_back(pc + 32'd48);
      run_program(1);
      check_fetches();
      check_store(0, 32'h100, pc + 32'd36 + 32'd4);
   endtask

   task automatic test_memory();
      word_t w;
      start_test("memory");
      w = $urandom();
      mem[8'd128] = w;
      emit(imm_op(3'b000, 5'd1, 5'd0, 12'h240));
      emit(load_op(5'd2, 5'd1, 12'hfc0));
      emit(imm_op(3'b000, 5'd3, 5'd0, 12'h100));
      emit(store_op(5'd2, 5'd3, 12'h024));
      emit(jal_op(5'd0, 21'd0));
      run_program(1);
      if (ld_adr_q.size() < 1) begin
         n_errors++;
         $display("%s: the load never reached the data bus", cur_test);
      end else begin
         check("load address", 32'h240 + sext12(12'hfc0), ld_adr_q[0]);
      end
      check_store(0, 32'h100 + sext12(12'h024), w);
   endtask

   task automatic test_x0();
      start_test("x0");
      emit(imm_op(3'b000, 5'd0, 5'd0, 12'd123));
      emit(lui_op(5'd0, 20'hfffff));
      emit(imm_op(3'b000, 5'd1, 5'd0, 12'd9));
      emit(reg_op(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
      emit(store_op(5'd0, 5'd0, 12'h100));
      emit(store_op(5'd1, 5'd0, 12'h104));
      emit(imm_op(3'b000, 5'd2, 5'd0, 12'd0));
      emit(store_op(5'd2, 5'd0, 12'h108));
      emit(jal_op(5'd0, 21'd0));
      run_program(3);
      check_store(0, 32'h100, 32'd0);
      check_store(1, 32'h104, 32'd9);
      check_store(2, 32'h108, 32'd0);
   endtask

   initial begin
      repeat (NUM_TESTS * MAX_PROG * CYCLES_PER_INSN) @(posedge clk);
      $display("Timeout in test %s, the core stopped making progress", cur_test);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      n_checks = 0;
      n_errors = 0;
      void'($urandom(32'haa7d));
      test_reset_pc();
      test_arith();
      test_logic();
      test_control_flow();
      test_memory();
      test_x0();
      $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* serv_top.f */
common/serv_pkg.sv
logic/serv_state.sv
decode/serv_decode.sv
logic/serv_bufreg.sv
logic/serv_ctrl.sv
logic/serv_alu.sv
logic/serv_rf.sv
logic/serv_mem_if.sv
logic/serv_top.sv
testbench/serv_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the serv_tb simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f serv_top.f --top-module serv_tb \
   -Mdir obj_dir -o serv_tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/serv_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
   exit 1
fi
exit 0
